/* dcache.f */
rtl/dcache_geom_pkg.sv
rtl/dcache_proto_pkg.sv
rtl/dcache_sram.sv
rtl/dcache_lookup_if.sv
rtl/dcache_tag_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_datapath.sv
rtl/dcache_top.sv
test/dcache_tb.sv

/* rtl/dcache_ctrl.sv */
//################################################
// request controller: one access at a time through
// lookup, hit, write-back of a dirty victim, refill
//################################################

`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       read_valid_i,
    input  logic                       write_valid_i,
    input  logic                       mem_ready_i,
    dcache_lookup_if.ctrl              lookup,
    output logic                       ready_o,
    output dcache_proto_pkg::mem_req_e mem_req_o,
    output logic                       data_we_o,
    output dcache_geom_pkg::way_t      data_way_o,
    output logic                       data_from_mem_o
);

    dcache_proto_pkg::ctrl_state_e state_q;
    dcache_proto_pkg::ctrl_state_e state_d;

    logic accept;
    logic refill_done;

    // exactly one valid starts a request
    assign accept      = read_valid_i ^ write_valid_i;
    assign refill_done = (state_q == dcache_proto_pkg::st_refill) && mem_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_proto_pkg::st_idle: begin
                if (accept) begin
                    state_d = dcache_proto_pkg::st_lookup;
                end
            end
            dcache_proto_pkg::st_lookup: begin
                if (lookup.hit) begin
                    state_d = dcache_proto_pkg::st_hit;
                end else if (lookup.victim_dirty) begin
                    state_d = dcache_proto_pkg::st_writeback;
                end else begin
                    state_d = dcache_proto_pkg::st_refill;
                end
            end
            dcache_proto_pkg::st_hit: begin
                state_d = dcache_proto_pkg::st_idle;
            end
            dcache_proto_pkg::st_writeback: begin
                if (mem_ready_i) begin
                    state_d = dcache_proto_pkg::st_refill;
                end
            end
            dcache_proto_pkg::st_refill: begin
                // back to lookup, the new line then hits
                if (mem_ready_i) begin
                    state_d = dcache_proto_pkg::st_lookup;
                end
            end
            default: begin
                state_d = dcache_proto_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dcache_proto_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign ready_o = (state_q == dcache_proto_pkg::st_hit);

    always_comb begin
        case (state_q)
            dcache_proto_pkg::st_writeback: mem_req_o = dcache_proto_pkg::req_writeback;
            dcache_proto_pkg::st_refill:    mem_req_o = dcache_proto_pkg::req_refill;
            default:                        mem_req_o = dcache_proto_pkg::req_none;
        endcase
    end

    assign lookup.fill_we      = refill_done;
    assign lookup.fill_way     = lookup.victim_way;
    assign lookup.hit_update   = ready_o;
    assign lookup.hit_is_write = write_valid_i;

    // hit cycle targets the hit way, misses target the victim
    assign data_way_o      = ready_o ? lookup.hit_way : lookup.victim_way;
    assign data_we_o       = (ready_o && write_valid_i) || refill_done;
    assign data_from_mem_o = (state_q == dcache_proto_pkg::st_refill);

    a_no_dual_request: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == dcache_proto_pkg::st_idle) |-> !(read_valid_i && write_valid_i)
    );

    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ((mem_req_o != dcache_proto_pkg::req_none) && !mem_ready_i) |=> $stable(mem_req_o)
    );

endmodule

/* rtl/dcache_datapath.sv */
//################################################
// data ways, byte-strobe merge on write hits and
// the address/data fields of memory requests
//################################################

`timescale 1ns/1ps

module dcache_datapath (
    input  logic                       clk,
    input  dcache_geom_pkg::addr_t     addr_i,
    input  dcache_geom_pkg::line_t     wdata_i,
    input  dcache_geom_pkg::strb_t     strb_i,
    input  dcache_geom_pkg::line_t     mem_rdata_i,
    input  dcache_proto_pkg::mem_req_e mem_req_i,
    input  logic                       data_we_i,
    input  dcache_geom_pkg::way_t      data_way_i,
    input  logic                       data_from_mem_i,
    dcache_lookup_if.data              lookup,
    output dcache_geom_pkg::line_t     rdata_o,
    output dcache_geom_pkg::addr_t     mem_addr_o,
    output dcache_geom_pkg::line_t     mem_wdata_o
);

    dcache_geom_pkg::index_t index;
    dcache_geom_pkg::tag_t   line_tag;
    dcache_geom_pkg::line_t  line_q [dcache_geom_pkg::num_ways];
    dcache_geom_pkg::line_t  merged;
    dcache_geom_pkg::line_t  fill_line;

    assign index = addr_i[dcache_geom_pkg::offset_w +: dcache_geom_pkg::index_w];

    always_comb begin
        merged = line_q[lookup.hit_way];
        for (int b = 0; b < dcache_geom_pkg::strb_w; b++) begin
            if (strb_i[b]) begin
                merged[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    assign fill_line = data_from_mem_i ? mem_rdata_i : merged;

    for (genvar w = 0; w < dcache_geom_pkg::num_ways; w++) begin : g_way
        dcache_sram #(
            .entry_t (dcache_geom_pkg::line_t),
            .depth   (dcache_geom_pkg::num_sets)
        ) data_ram_inst (
            .clk     (clk),
            .addr_i  (index),
            .we_i    (data_we_i && (data_way_i == w)),
            .wdata_i (fill_line),
            .rdata_o (line_q[w])
        );
    end

    assign rdata_o = line_q[lookup.hit_way];

    // write-back goes to the victim's own line address
    assign line_tag = (mem_req_i == dcache_proto_pkg::req_writeback) ?
                      lookup.victim_tag :
                      addr_i[dcache_geom_pkg::addr_w-1 -: dcache_geom_pkg::tag_w];

    assign mem_addr_o  = {line_tag, index, {dcache_geom_pkg::offset_w{1'b0}}};
    assign mem_wdata_o = line_q[data_way_i];

endmodule

/* rtl/dcache_geom_pkg.sv */
//################################################
// geometry of the two-way data cache: widths,
// address fields and storage types, referenced by
// scoped name from the tag store, datapath and top
//################################################

package dcache_geom_pkg;

    localparam int addr_w   = 32;
    localparam int data_w   = 64;
    localparam int strb_w   = data_w / 8;
    localparam int offset_w = 3;
    localparam int index_w  = 6;
    localparam int num_sets = 1 << index_w;
    localparam int tag_w    = addr_w - index_w - offset_w;
    localparam int num_ways = 2;

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [data_w-1:0]   line_t;
    typedef logic [strb_w-1:0]   strb_t;

    // one bit names the way
    typedef logic [$clog2(num_ways)-1:0] way_t;

endpackage

/* rtl/dcache_lookup_if.sv */
//################################################
// lookup results from the tag store and fill/hit
// commands from the controller
//################################################

`timescale 1ns/1ps

interface dcache_lookup_if;

    logic                  hit;
    dcache_geom_pkg::way_t hit_way;
    dcache_geom_pkg::way_t victim_way;
    logic                  victim_dirty;
    dcache_geom_pkg::tag_t victim_tag;

    logic                  fill_we;
    dcache_geom_pkg::way_t fill_way;
    logic                  hit_update;
    logic                  hit_is_write;

    modport tag (
        output hit, hit_way, victim_way, victim_dirty, victim_tag,
        input  fill_we, fill_way, hit_update, hit_is_write
    );

    modport ctrl (
        input  hit, hit_way, victim_way, victim_dirty,
        output fill_we, fill_way, hit_update, hit_is_write
    );

    modport data (
        input hit_way, victim_tag
    );

endinterface

/* rtl/dcache_proto_pkg.sv */
//################################################
// controller states and next-level memory request
// kinds shared by controller, datapath and top
//################################################

package dcache_proto_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_hit,
        st_writeback,
        st_refill
    } ctrl_state_e;

    typedef enum logic [1:0] {
        req_none,
        req_writeback,
        req_refill
    } mem_req_e;

endpackage

/* rtl/dcache_sram.sv */
//################################################
// single-port synchronous array, write-first
// instantiated for tag entries and for data lines
//################################################

`timescale 1ns/1ps

module dcache_sram #(
    parameter type entry_t = logic [63:0],
    parameter int  depth   = 64
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr_i,
    input  logic                     we_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem [depth];

    // same-address write shows up on the read port at once
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
            rdata_o     <= wdata_i;
        end else begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* rtl/dcache_tag_store.sv */
//################################################
// tag arrays plus valid, dirty and LRU flops
// reports hit and victim for the held request
//################################################

`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  dcache_geom_pkg::addr_t addr_i,
    dcache_lookup_if.tag           lookup
);

    dcache_geom_pkg::tag_t   req_tag;
    dcache_geom_pkg::index_t index;
    dcache_geom_pkg::tag_t   tag_q [dcache_geom_pkg::num_ways];
    dcache_geom_pkg::way_t   victim;

    logic [dcache_geom_pkg::num_ways-1:0] way_hit;
    logic [dcache_geom_pkg::num_sets-1:0] valid_q [dcache_geom_pkg::num_ways];
    logic [dcache_geom_pkg::num_sets-1:0] dirty_q [dcache_geom_pkg::num_ways];
    // lru_q names the way to evict next
    logic [dcache_geom_pkg::num_sets-1:0] lru_q;

    assign req_tag = addr_i[dcache_geom_pkg::addr_w-1 -: dcache_geom_pkg::tag_w];
    assign index   = addr_i[dcache_geom_pkg::offset_w +: dcache_geom_pkg::index_w];

    for (genvar w = 0; w < dcache_geom_pkg::num_ways; w++) begin : g_way
        dcache_sram #(
            .entry_t (dcache_geom_pkg::tag_t),
            .depth   (dcache_geom_pkg::num_sets)
        ) tag_ram_inst (
            .clk     (clk),
            .addr_i  (index),
            .we_i    (lookup.fill_we && (lookup.fill_way == w)),
            .wdata_i (req_tag),
            .rdata_o (tag_q[w])
        );

        assign way_hit[w] = valid_q[w][index] && (tag_q[w] == req_tag);
    end

    assign lookup.hit     = |way_hit;
    assign lookup.hit_way = dcache_geom_pkg::way_t'(way_hit[1]);

    // invalid ways first, otherwise the older one
    always_comb begin
        if (!valid_q[0][index]) begin
            victim = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[index];
        end
    end

    assign lookup.victim_way   = victim;
    assign lookup.victim_dirty = dirty_q[victim][index];
    assign lookup.victim_tag   = tag_q[victim];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (lookup.fill_we) begin
                valid_q[lookup.fill_way][index] <= 1'b1;
                dirty_q[lookup.fill_way][index] <= 1'b0;
                lru_q[index]                    <= ~lookup.fill_way;
            end
            if (lookup.hit_update) begin
                lru_q[index] <= ~lookup.hit_way;
                if (lookup.hit_is_write) begin
                    dirty_q[lookup.hit_way][index] <= 1'b1;
                end
            end
        end
    end

    // a refill never installs a tag already present in the set
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(way_hit[0] && way_hit[1])
    );

endmodule

/* rtl/dcache_top.sv */
//################################################
// two-way write-back data cache, plain request
// ports and a strobe interface to next-level memory
//################################################

`timescale 1ns/1ps

module dcache_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       read_valid_i,
    input  logic                       write_valid_i,
    input  dcache_geom_pkg::addr_t     addr_i,
    input  dcache_geom_pkg::line_t     wdata_i,
    input  dcache_geom_pkg::strb_t     strb_i,
    output dcache_geom_pkg::line_t     rdata_o,
    output logic                       ready_o,
    output dcache_proto_pkg::mem_req_e mem_req_o,
    output dcache_geom_pkg::addr_t     mem_addr_o,
    output dcache_geom_pkg::line_t     mem_wdata_o,
    input  logic                       mem_ready_i,
    input  dcache_geom_pkg::line_t     mem_rdata_i
);

    logic                  data_we;
    dcache_geom_pkg::way_t data_way;
    logic                  data_from_mem;

    dcache_lookup_if lookup_if ();

    dcache_tag_store tag_store_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (addr_i),
        .lookup  (lookup_if)
    );

    dcache_ctrl ctrl_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .read_valid_i    (read_valid_i),
        .write_valid_i   (write_valid_i),
        .mem_ready_i     (mem_ready_i),
        .lookup          (lookup_if),
        .ready_o         (ready_o),
        .mem_req_o       (mem_req_o),
        .data_we_o       (data_we),
        .data_way_o      (data_way),
        .data_from_mem_o (data_from_mem)
    );

    dcache_datapath datapath_inst (
        .clk             (clk),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .strb_i          (strb_i),
        .mem_rdata_i     (mem_rdata_i),
        .mem_req_i       (mem_req_o),
        .data_we_i       (data_we),
        .data_way_i      (data_way),
        .data_from_mem_i (data_from_mem),
        .lookup          (lookup_if),
        .rdata_o         (rdata_o),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb \
    -f dcache.f \
    --Mdir obj_dir \
    -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"

/* test/dcache_tb.sv */
//################################################
// directed and random tests for the two-way cache
// with a delayed next-level memory model and a
// byte-wide reference memory for expected data
//################################################

`timescale 1ns/1ps

module dcache_tb;

    localparam int clk_period_ns     = 8;
    localparam int reset_cycles      = 16;
    localparam int access_budget     = 220;
    localparam int cycles_per_access = 20;
    localparam int ready_limit       = 40;
    // twice the worst case of all accesses
    localparam int watchdog_ns =
        2 * clk_period_ns * (reset_cycles + access_budget * cycles_per_access);

    logic                       clk = 1'b0;
    logic                       rst_n_i;
    logic                       read_valid_i;
    logic                       write_valid_i;
    dcache_geom_pkg::addr_t     addr_i;
    dcache_geom_pkg::line_t     wdata_i;
    dcache_geom_pkg::strb_t     strb_i;
    dcache_geom_pkg::line_t     rdata_o;
    logic                       ready_o;
    dcache_proto_pkg::mem_req_e mem_req_o;
    dcache_geom_pkg::addr_t     mem_addr_o;
    dcache_geom_pkg::line_t     mem_wdata_o;
    logic                       mem_ready_i = 1'b0;
    dcache_geom_pkg::line_t     mem_rdata_i = '0;

    integer seed = 32'hffac_7611;
    int     errors = 0;
    int     reads_checked = 0;
    int     refill_count = 0;
    int     wb_count = 0;
    int     mem_delay;
    logic   mem_pending = 1'b0;

    dcache_geom_pkg::addr_t last_refill_addr;
    dcache_geom_pkg::addr_t last_wb_addr;
    dcache_geom_pkg::line_t last_wb_data;

    // next-level words by line address, reference bytes by byte address
    dcache_geom_pkg::line_t mem_words [dcache_geom_pkg::addr_t];
    logic [7:0]             ref_bytes [dcache_geom_pkg::addr_t];

    dcache_top dcache_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .read_valid_i  (read_valid_i),
        .write_valid_i (write_valid_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .strb_i        (strb_i),
        .rdata_o       (rdata_o),
        .ready_o       (ready_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    // content of a word never written back
    function automatic dcache_geom_pkg::line_t fill_word(input dcache_geom_pkg::addr_t a);
        return {a ^ 32'h9e37_79b9, ~a ^ {a[15:0], a[31:16]}};
    endfunction

    function automatic dcache_geom_pkg::line_t stored_word(input dcache_geom_pkg::addr_t a);
        return mem_words.exists(a) ? mem_words[a] : fill_word(a);
    endfunction

    function automatic dcache_geom_pkg::line_t expected_word(input dcache_geom_pkg::addr_t a);
        dcache_geom_pkg::addr_t line;
        dcache_geom_pkg::line_t word;
        line = a & ~32'h7;
        word = fill_word(line);
        for (int b = 0; b < 8; b++) begin
            if (ref_bytes.exists(line + b)) begin
                word[8*b +: 8] = ref_bytes[line + b];
            end
        end
        return word;
    endfunction

    task automatic apply_write(input dcache_geom_pkg::addr_t a,
                               input dcache_geom_pkg::line_t data,
                               input dcache_geom_pkg::strb_t strb);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                ref_bytes[(a & ~32'h7) + b] = data[8*b +: 8];
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    endtask

    // memory model, answers 1 to 4 cycles after a request shows up
    always @(posedge clk) begin
        if (!rst_n_i) begin
            mem_ready_i <= 1'b0;
            mem_pending = 1'b0;
        end else if (mem_ready_i) begin
            mem_ready_i <= 1'b0;
            mem_pending = 1'b0;
        end else if (mem_req_o != dcache_proto_pkg::req_none) begin
            if (!mem_pending) begin
                mem_pending = 1'b1;
                mem_delay   = 1 + ($random(seed) & 3);
                if (mem_addr_o[2:0] != 3'b000) begin
                    report_mismatch("mem_addr_o", 64'(mem_addr_o & ~32'h7), 64'(mem_addr_o));
                end
            end
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                mem_ready_i <= 1'b1;
                if (mem_req_o == dcache_proto_pkg::req_writeback) begin
                    mem_words[mem_addr_o] = mem_wdata_o;
                    last_wb_addr = mem_addr_o;
                    last_wb_data = mem_wdata_o;
                    wb_count++;
                end else begin
                    mem_rdata_i <= stored_word(mem_addr_o);
                    last_refill_addr = mem_addr_o;
                    refill_count++;
                end
            end
        end
    end

    task automatic access(input logic is_write, input dcache_geom_pkg::addr_t addr,
                          input dcache_geom_pkg::line_t wdata,
                          input dcache_geom_pkg::strb_t strb,
                          output dcache_geom_pkg::line_t rdata, output int cycles);
        @(posedge clk);
        read_valid_i  <= !is_write;
        write_valid_i <= is_write;
        addr_i        <= addr;
        wdata_i       <= wdata;
        strb_i        <= strb;
        // accepting edge
        @(posedge clk);
        cycles = 0;
        rdata  = '0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ready_o && cycles < ready_limit);
        if (ready_o) begin
            rdata = rdata_o;
        end else begin
            errors++;
            $display("no ready_o within %0d cycles for access to %h", ready_limit, addr);
        end
        @(posedge clk);
        read_valid_i  <= 1'b0;
        write_valid_i <= 1'b0;
    endtask

    task automatic write_word(input dcache_geom_pkg::addr_t addr,
                              input dcache_geom_pkg::line_t data,
                              input dcache_geom_pkg::strb_t strb, output int cycles);
        dcache_geom_pkg::line_t unused;
        apply_write(addr, data, strb);
        access(1'b1, addr, data, strb, unused, cycles);
    endtask

    task automatic read_check(input dcache_geom_pkg::addr_t addr, output int cycles);
        dcache_geom_pkg::line_t expected;
        dcache_geom_pkg::line_t actual;
        expected = expected_word(addr);
        access(1'b0, addr, '0, '0, actual, cycles);
        reads_checked++;
        if (actual !== expected) begin
            report_mismatch("rdata_o", expected, actual);
        end
    endtask

    task automatic test_reset_state();
        repeat (4) begin
            @(negedge clk);
            if (ready_o !== 1'b0) begin
                report_mismatch("ready_o", 64'h0, 64'(ready_o));
            end
            if (mem_req_o !== dcache_proto_pkg::req_none) begin
                report_mismatch("mem_req_o", 64'(dcache_proto_pkg::req_none), 64'(mem_req_o));
            end
        end
    endtask

    task automatic test_read_miss_hit();
        dcache_geom_pkg::addr_t addr;
        dcache_geom_pkg::addr_t line_addr;
        int                     refills;
        int                     wbs;
        int                     cycles;
        // byte offset 4 inside the word
        addr      = 32'h0001_234c;
        line_addr = 32'h0001_2348;
        refills   = refill_count;
        wbs       = wb_count;
        read_check(addr, cycles);
        if (refill_count != refills + 1 || wb_count != wbs) begin
            errors++;
            $display("first read of %h did not raise exactly one refill", addr);
        end
        if (last_refill_addr !== line_addr) begin
            report_mismatch("mem_addr_o", 64'(line_addr), 64'(last_refill_addr));
        end
        refills = refill_count;
        read_check(addr, cycles);
        if (cycles != 2) begin
            report_mismatch("ready_o latency", 64'h2, 64'(cycles));
        end
        if (refill_count != refills || wb_count != wbs) begin
            errors++;
            $display("repeated read of %h went to memory", addr);
        end
    endtask

    task automatic test_write_strobe();
        int cycles;
        write_word(32'h0001_2348, 64'h1122_3344_5566_7788, 8'b1010_0101, cycles);
        if (cycles != 2) begin
            report_mismatch("ready_o latency", 64'h2, 64'(cycles));
        end
        read_check(32'h0001_2348, cycles);
    endtask

    task automatic test_dirty_eviction();
        dcache_geom_pkg::addr_t a1;
        dcache_geom_pkg::addr_t a2;
        dcache_geom_pkg::addr_t a3;
        int                     wbs;
        int                     cycles;
        // three tags on index 5
        a1 = 32'h0010_0028;
        a2 = 32'h0020_0028;
        a3 = 32'h0030_0028;
        write_word(a1, 64'hdead_beef_0bad_f00d, 8'b0011_1100, cycles);
        read_check(a2, cycles);
        wbs = wb_count;
        read_check(a3, cycles);
        if (wb_count != wbs + 1) begin
            errors++;
            $display("read of %h did not write back the dirty line", a3);
        end
        if (last_wb_addr !== a1) begin
            report_mismatch("mem_addr_o", 64'(a1), 64'(last_wb_addr));
        end
        if (last_wb_data !== expected_word(a1)) begin
            report_mismatch("mem_wdata_o", expected_word(a1), last_wb_data);
        end
        if (last_refill_addr !== a3) begin
            report_mismatch("mem_addr_o", 64'(a3), 64'(last_refill_addr));
        end
        read_check(a1, cycles);
    endtask

    task automatic test_random_traffic();
        dcache_geom_pkg::addr_t addr;
        dcache_geom_pkg::line_t data;
        dcache_geom_pkg::strb_t strb;
        logic                   is_write;
        int                     cycles;
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            // four tags over indices 12 and 13
            addr      = ((($random(seed) & 3) + 1) << 18) | ((12 + ($random(seed) & 1)) << 3);
            // any byte offset inside the word
            addr[2:0] = 3'($random(seed));
            data      = {$random(seed), $random(seed)};
            strb      = 8'($random(seed));
            is_write  = 1'($random(seed));
            if (is_write) begin
                write_word(addr, data, strb, cycles);
            end else begin
                read_check(addr, cycles);
            end
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst_n_i       = 1'b0;
        read_valid_i  = 1'b0;
        write_valid_i = 1'b0;
        addr_i        = '0;
        wdata_i       = '0;
        strb_i        = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset_state();
        test_read_miss_hit();
        test_write_strobe();
        test_dirty_eviction();
        test_random_traffic();
        $display("reads checked: %0d, refills: %0d, write-backs: %0d, errors: %0d",
                 reads_checked, refill_count, wb_count, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
